// File: icache_pf_settings.svh
// Size macros and address field split for the multi-core instruction cache
`ifndef ICACHE_PF_SETTINGS_SVH
`define ICACHE_PF_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Basic sizes
`define ICACHE_NB_CORES    4                  // Fetching cores
`define ICACHE_ADDR_W      32                 // Fetch address bits
`define ICACHE_LINE_W      128                // One cache line
`define ICACHE_AXI_DATA_W  64                 // One AXI beat
`define ICACHE_NB_SETS     16                 // Direct mapped, one line per set

// One-hot requester ID, top bit is the prefetcher
`define ICACHE_ID_W        (`ICACHE_NB_CORES + 1)

////////////////////////////////////////////////////////////
// Address split {tag, index, offset}
`define ICACHE_OFFSET_W    $clog2(`ICACHE_LINE_W / 8)
`define ICACHE_INDEX_W     $clog2(`ICACHE_NB_SETS)
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)
`define ICACHE_LINE_ADDR_W (`ICACHE_ADDR_W - `ICACHE_OFFSET_W)
`define ICACHE_BEATS       (`ICACHE_LINE_W / `ICACHE_AXI_DATA_W)

`endif

// File: icache_pf_pkg.sv
// Request, refill and AXI read channel structs of the instruction cache
`default_nettype none
`include "icache_pf_settings.svh"

package icache_pf_pkg;

   ////////////////////////////////////////////////////////////
   // Internal links

   // Fetch request as it leaves the arbiter
   typedef struct packed {
      logic [`ICACHE_ID_W-1:0]        id;         // One-hot requester
      logic [`ICACHE_ADDR_W-1:0]      addr;       // Byte address
   } fetch_req_t;

   // Completed line from the refill stage
   typedef struct packed {
      logic [`ICACHE_ID_W-1:0]        id;         // Who missed
      logic [`ICACHE_LINE_ADDR_W-1:0] line_addr;  // {tag, index}
      logic [`ICACHE_LINE_W-1:0]      data;       // Beat 1 high, beat 0 low
   } refill_t;

   ////////////////////////////////////////////////////////////
   // AXI read channels

   typedef struct packed {
      logic [`ICACHE_ID_W-1:0]        arid;
      logic [`ICACHE_ADDR_W-1:0]      araddr;
      logic [7:0]                     arlen;      // Beats minus one
      logic [2:0]                     arsize;     // log2 bytes per beat
      logic [1:0]                     arburst;    // INCR only
   } axi_ar_t;

   typedef struct packed {
      logic [`ICACHE_ID_W-1:0]        rid;
      logic [`ICACHE_AXI_DATA_W-1:0]  rdata;
      logic [1:0]                     rresp;
      logic                           rlast;      // Last beat of the burst
   } axi_r_t;

endpackage

`default_nettype wire

// File: icache_pf_arbiter.sv
// Round-robin arbiter for the core fetch ports, prefetch channel served last
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module icache_pf_arbiter (
   input  logic                                            clk,
   input  logic                                            rst_n_i,
   input  logic [`ICACHE_NB_CORES-1:0]                     core_req_i,
   input  logic [`ICACHE_NB_CORES-1:0][`ICACHE_ADDR_W-1:0] core_addr_i,
   output logic [`ICACHE_NB_CORES-1:0]                     core_gnt_o,
   input  logic                                            pf_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]                       pf_addr_i,
   output logic                                            pf_gnt_o,
   output icache_pf_pkg::fetch_req_t                       req_o,
   output logic                                            req_valid_o,
   input  logic                                            req_ready_i
);

   localparam int NB    = `ICACHE_NB_CORES;
   localparam int IDX_W = (NB > 1) ? $clog2(NB) : 1;

   logic [IDX_W-1:0] rr_ptr_q;   // Core with top priority
   logic [IDX_W-1:0] scan_idx;
   logic [IDX_W-1:0] win_idx;    // Winning core
   logic             core_any;   // Some core requests
   logic [NB-1:0]    win_oh;

   ////////////////////////////////////////////////////////////
   // Search from the pointer, wrapping around
   always_comb begin
      core_any = 1'b0;
      win_idx  = rr_ptr_q;
      scan_idx = rr_ptr_q;
      for (int k = 0; k < NB; k++) begin
         scan_idx = IDX_W'((int'(rr_ptr_q) + k) % NB);
         if (!core_any && core_req_i[scan_idx]) begin
            core_any = 1'b1;     // First requester wins
            win_idx  = scan_idx;
         end
      end
   end

   assign win_oh = {{(NB-1){1'b0}}, 1'b1} << win_idx;

   // Cores always beat the prefetcher
   always_comb begin
      if (core_any) begin
         req_o.id   = {1'b0, win_oh};
         req_o.addr = core_addr_i[win_idx];
      end else begin
         req_o.id   = {1'b1, {NB{1'b0}}};   // Prefetch ID bit
         req_o.addr = pf_addr_i;
      end
   end

   assign req_valid_o = core_any | pf_req_i;
   assign core_gnt_o  = (core_any && req_ready_i) ? win_oh : '0;
   assign pf_gnt_o    = pf_req_i && !core_any && req_ready_i;

   ////////////////////////////////////////////////////////////
   // Pointer moves past the last granted core
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rr_ptr_q <= '0;
      end else if (core_any && req_ready_i) begin
         rr_ptr_q <= IDX_W'((int'(win_idx) + 1) % NB);
      end
   end

endmodule

`default_nettype wire

// File: icache_pf_stage_reg.sv
// One-entry valid/ready pipeline register with a payload type parameter
`timescale 1ns/10ps
`default_nettype none

module icache_pf_stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n_i,
   input  payload_t in_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output payload_t out_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);

   logic     full_q;
   logic     push;
   payload_t data_q;

   // Room when empty or draining this cycle
   assign in_ready_o  = !full_q || out_ready_i;
   assign push        = in_valid_i && in_ready_o;
   assign out_valid_o = full_q;
   assign out_o       = data_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
      end else if (push) begin
         full_q <= 1'b1;            // Fill, possibly while draining
      end else if (out_ready_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_q <= in_i;
      end
   end

endmodule

`default_nettype wire

// File: icache_pf_lookup.sv
// Tag, valid and data arrays with hit check, flush, responses and miss hand-off
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module icache_pf_lookup (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  icache_pf_pkg::fetch_req_t           req_i,
   input  logic                                req_valid_i,
   output logic                                req_ready_o,
   input  logic                                flush_req_i,
   output logic                                flush_ack_o,
   output icache_pf_pkg::fetch_req_t           miss_o,
   output logic                                miss_valid_o,
   input  logic                                miss_ready_i,
   input  icache_pf_pkg::refill_t              refill_i,
   input  logic                                refill_valid_i,
   output logic [`ICACHE_NB_CORES-1:0]         core_rvalid_o,
   output logic [`ICACHE_LINE_W-1:0]           core_rdata_o,
   output logic                                pf_rvalid_o
);

   localparam int NB    = `ICACHE_NB_CORES;
   localparam int OFF_W = `ICACHE_OFFSET_W;
   localparam int IDX_W = `ICACHE_INDEX_W;
   localparam int TAG_W = `ICACHE_TAG_W;

   ////////////////////////////////////////////////////////////
   // Arrays
   logic [TAG_W-1:0]              tag_q  [`ICACHE_NB_SETS];
   logic [`ICACHE_LINE_W-1:0]     data_q [`ICACHE_NB_SETS];
   logic [`ICACHE_NB_SETS-1:0]    valid_q;

   logic [IDX_W-1:0]              req_idx, rf_idx;
   logic [TAG_W-1:0]              req_tag, rf_tag;
   logic                          hit;
   logic                          take;          // Request accepted this cycle
   logic                          flush_go;

   logic                          busy_q;        // Miss outstanding, input stalled
   logic                          miss_valid_q;
   icache_pf_pkg::fetch_req_t     miss_q;
   logic                          flush_seen_q;  // Flush done, wait for request drop
   logic                          flush_ack_q;
   logic                          rsp_valid_q;
   logic [`ICACHE_ID_W-1:0]       rsp_id_q;
   logic [`ICACHE_LINE_W-1:0]     rsp_line_q;

   assign req_idx = req_i.addr[OFF_W +: IDX_W];
   assign req_tag = req_i.addr[`ICACHE_ADDR_W-1 -: TAG_W];
   assign rf_idx  = refill_i.line_addr[IDX_W-1:0];
   assign rf_tag  = refill_i.line_addr[IDX_W +: TAG_W];

   assign hit         = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
   assign req_ready_o = !busy_q && !flush_req_i;   // Blocking, one miss at a time
   assign take        = req_valid_i && req_ready_o;
   assign flush_go    = flush_req_i && !busy_q && !flush_seen_q;

   ////////////////////////////////////////////////////////////
   // Control state
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         busy_q       <= 1'b0;
         miss_valid_q <= 1'b0;
         flush_seen_q <= 1'b0;
         flush_ack_q  <= 1'b0;
         rsp_valid_q  <= 1'b0;
         valid_q      <= '0;
      end else begin
         rsp_valid_q <= (take && hit) || refill_valid_i;
         flush_ack_q <= flush_go;                     // One pulse per flush
         if (flush_go) begin
            flush_seen_q <= 1'b1;
         end else if (!flush_req_i) begin
            flush_seen_q <= 1'b0;
         end
         if (miss_valid_q && miss_ready_i) begin
            miss_valid_q <= 1'b0;                     // Refill stage took it
         end
         if (take && !hit) begin
            busy_q       <= 1'b1;
            miss_valid_q <= 1'b1;
         end
         if (refill_valid_i) begin
            busy_q          <= 1'b0;                  // Line arrived, resume
            valid_q[rf_idx] <= 1'b1;
         end
         if (flush_go) begin
            valid_q <= '0;                            // Invalidate all lines
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Array writes and response payload
   always_ff @(posedge clk) begin
      if (take && !hit) begin
         miss_q <= req_i;
      end
      if (take && hit) begin
         rsp_id_q   <= req_i.id;
         rsp_line_q <= data_q[req_idx];
      end
      if (refill_valid_i) begin
         tag_q[rf_idx]  <= rf_tag;
         data_q[rf_idx] <= refill_i.data;
         rsp_id_q       <= refill_i.id;               // Answer the requester that missed
         rsp_line_q     <= refill_i.data;
      end
   end

   assign miss_o        = miss_q;
   assign miss_valid_o  = miss_valid_q;
   assign flush_ack_o   = flush_ack_q;
   // Route by one-hot ID, prefetch gets only the pulse
   assign core_rvalid_o = rsp_valid_q ? rsp_id_q[NB-1:0] : '0;
   assign pf_rvalid_o   = rsp_valid_q && rsp_id_q[NB];
   assign core_rdata_o  = rsp_line_q;

endmodule

`default_nettype wire

// File: icache_pf_refill.sv
// AXI read address issue and two-beat line assembly for one outstanding miss
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module icache_pf_refill (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  icache_pf_pkg::fetch_req_t   miss_i,
   input  logic                        miss_valid_i,
   output logic                        miss_ready_o,
   output icache_pf_pkg::axi_ar_t      ar_o,
   output logic                        arvalid_o,
   input  logic                        arready_i,
   input  icache_pf_pkg::axi_r_t       r_i,
   input  logic                        rvalid_i,
   output icache_pf_pkg::refill_t      refill_o,
   output logic                        refill_valid_o
);

   localparam int OFF_W = `ICACHE_OFFSET_W;

   typedef enum logic [1:0] {IDLE, ADDR, DATA} state_e;

   state_e                          state_q;
   icache_pf_pkg::fetch_req_t       req_q;    // Outstanding miss
   logic [`ICACHE_AXI_DATA_W-1:0]   beat0_q;  // First beat, low half
   logic                            beat_ok;

   assign miss_ready_o = (state_q == IDLE);
   assign arvalid_o    = (state_q == ADDR);   // Held until arready_i
   // Only beats of our own ID count
   assign beat_ok      = (state_q == DATA) && rvalid_i && (r_i.rid == req_q.id);

   ////////////////////////////////////////////////////////////
   // AR fields, stable while in ADDR
   always_comb begin
      ar_o.arid    = req_q.id;
      ar_o.araddr  = {req_q.addr[`ICACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};  // Line aligned
      ar_o.arlen   = 8'(`ICACHE_BEATS - 1);
      ar_o.arsize  = 3'($clog2(`ICACHE_AXI_DATA_W / 8));
      ar_o.arburst = 2'b01;                                             // INCR
   end

   // Line goes out with the rlast beat
   always_comb begin
      refill_o.id        = req_q.id;
      refill_o.line_addr = req_q.addr[`ICACHE_ADDR_W-1:OFF_W];
      refill_o.data      = {r_i.rdata, beat0_q};
   end
   assign refill_valid_o = beat_ok && r_i.rlast;

   ////////////////////////////////////////////////////////////
   // FSM
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE:    if (miss_valid_i) state_q <= ADDR;
            ADDR:    if (arready_i) state_q <= DATA;
            DATA:    if (beat_ok && r_i.rlast) state_q <= IDLE;   // Refill delivered
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (miss_valid_i && miss_ready_o) begin
         req_q <= miss_i;
      end
      if (beat_ok && !r_i.rlast) begin
         beat0_q <= r_i.rdata;
      end
   end

endmodule

`default_nettype wire

// File: icache_pf_top.sv
// Top level of the instruction cache with prefetch port and AXI read master
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module icache_pf_top (
   input  logic                                            clk,
   input  logic                                            rst_n_i,
   input  logic [`ICACHE_NB_CORES-1:0]                     fetch_req_i,
   input  logic [`ICACHE_NB_CORES-1:0][`ICACHE_ADDR_W-1:0] fetch_addr_i,
   output logic [`ICACHE_NB_CORES-1:0]                     fetch_gnt_o,
   output logic [`ICACHE_NB_CORES-1:0]                     fetch_rvalid_o,
   output logic [`ICACHE_NB_CORES-1:0][`ICACHE_LINE_W-1:0] fetch_rdata_o,
   input  logic                                            pf_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]                       pf_addr_i,
   output logic                                            pf_gnt_o,
   output logic                                            pf_rvalid_o,
   input  logic                                            flush_req_i,
   output logic                                            flush_ack_o,
   output icache_pf_pkg::axi_ar_t                          axi_ar_o,
   output logic                                            axi_arvalid_o,
   input  logic                                            axi_arready_i,
   input  icache_pf_pkg::axi_r_t                           axi_r_i,
   input  logic                                            axi_rvalid_i,
   output logic                                            axi_rready_o
);

   icache_pf_pkg::fetch_req_t  arb_req, lk_req, miss;
   icache_pf_pkg::refill_t     rf_line, rf_line_q;
   logic                       arb_valid, arb_ready, lk_valid, lk_ready;
   logic                       miss_valid, miss_ready, rf_valid, rf_valid_q;
   logic [`ICACHE_LINE_W-1:0]  rsp_line;

   ////////////////////////////////////////////////////////////
   // Request path
   icache_pf_arbiter u_arbiter (
      .clk, .rst_n_i,
      .core_req_i  (fetch_req_i),  .core_addr_i (fetch_addr_i), .core_gnt_o (fetch_gnt_o),
      .pf_req_i    (pf_req_i),     .pf_addr_i   (pf_addr_i),    .pf_gnt_o   (pf_gnt_o),
      .req_o       (arb_req),      .req_valid_o (arb_valid),    .req_ready_i (arb_ready)
   );

   icache_pf_stage_reg #(.payload_t(icache_pf_pkg::fetch_req_t)) u_req_reg (
      .clk, .rst_n_i,
      .in_i  (arb_req), .in_valid_i  (arb_valid), .in_ready_o  (arb_ready),
      .out_o (lk_req),  .out_valid_o (lk_valid),  .out_ready_i (lk_ready)
   );

   icache_pf_lookup u_lookup (
      .clk, .rst_n_i,
      .req_i         (lk_req),      .req_valid_i    (lk_valid),    .req_ready_o  (lk_ready),
      .flush_req_i   (flush_req_i), .flush_ack_o    (flush_ack_o),
      .miss_o        (miss),        .miss_valid_o   (miss_valid),  .miss_ready_i (miss_ready),
      .refill_i      (rf_line_q),   .refill_valid_i (rf_valid_q),
      .core_rvalid_o (fetch_rvalid_o), .core_rdata_o (rsp_line),   .pf_rvalid_o  (pf_rvalid_o)
   );

   ////////////////////////////////////////////////////////////
   // Miss path to AXI
   icache_pf_refill u_refill (
      .clk, .rst_n_i,
      .miss_i   (miss),          .miss_valid_i (miss_valid),    .miss_ready_o (miss_ready),
      .ar_o     (axi_ar_o),      .arvalid_o    (axi_arvalid_o), .arready_i    (axi_arready_i),
      .r_i      (axi_r_i),       .rvalid_i     (axi_rvalid_i),
      .refill_o (rf_line),       .refill_valid_o (rf_valid)
   );

   // Refill register, lookup always takes it
   icache_pf_stage_reg #(.payload_t(icache_pf_pkg::refill_t)) u_refill_reg (
      .clk, .rst_n_i,
      .in_i  (rf_line),   .in_valid_i  (rf_valid),   .in_ready_o  (),
      .out_o (rf_line_q), .out_valid_o (rf_valid_q), .out_ready_i (1'b1)
   );

   assign fetch_rdata_o = {`ICACHE_NB_CORES{rsp_line}};  // Qualified by each rvalid bit
   assign axi_rready_o  = 1'b1;                           // R beats always accepted

endmodule

`default_nettype wire

// File: icache_pf_asserts.sv
// Bound assertions on the AR handshake, response routing and flush acknowledge
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module icache_pf_asserts (
   input logic                        clk,
   input logic                        rst_n_i,
   input icache_pf_pkg::axi_ar_t      axi_ar_o,
   input logic                        axi_arvalid_o,
   input logic                        axi_arready_i,
   input logic [`ICACHE_NB_CORES-1:0] fetch_rvalid_o,
   input logic                        flush_req_i,
   input logic                        flush_ack_o
);

   int fail_cnt = 0;   // Failed assertion count

   ////////////////////////////////////////////////////////////
   // AR held with stable fields until accepted
   ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_ar_o))
      else begin
         $error("AR dropped or changed before arready");
         fail_cnt++;
      end

   // One core answered per cycle
   rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(fetch_rvalid_o))
      else begin
         $error("several fetch responses in one cycle");
         fail_cnt++;
      end

   ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      flush_ack_o |=> !flush_ack_o)
      else begin
         $error("flush acknowledge longer than one cycle");
         fail_cnt++;
      end

   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      flush_ack_o |-> $past(flush_req_i))   // Ack only follows a request
      else begin
         $error("flush acknowledge without a prior request");
         fail_cnt++;
      end

endmodule

bind icache_pf_top icache_pf_asserts u_asserts (.*);

`default_nettype wire

// File: tb_icache_pf.sv
// Testbench for the instruction cache with stimulus table, AXI memory model and watchdog
`timescale 1ns/10ps
`default_nettype none
`include "icache_pf_settings.svh"

module tb_icache_pf;

   localparam int PERIOD = 40;
   localparam int NROWS  = 14;
   localparam int NB     = `ICACHE_NB_CORES;

   typedef struct packed {
      logic                      flush;    // Flush row without a fetch
      logic [NB:0]               who;      // Requesters with the prefetcher on the top bit
      logic [31:0]               addr;     // Address of the lowest requester
      logic [31:0]               stride;   // Address step between requesters
      logic [3:0]                exp_ar;   // New AR bursts expected
      logic [`ICACHE_LINE_W-1:0] line;     // Expected line at addr
   } row_t;

   logic                                    clk, rst_n_i;
   logic [NB-1:0]                           fetch_req_i, fetch_gnt_o, fetch_rvalid_o;
   logic [NB-1:0][`ICACHE_ADDR_W-1:0]       fetch_addr_i;
   logic [NB-1:0][`ICACHE_LINE_W-1:0]       fetch_rdata_o;
   logic                                    pf_req_i, pf_gnt_o, pf_rvalid_o;
   logic [`ICACHE_ADDR_W-1:0]               pf_addr_i;
   logic                                    flush_req_i, flush_ack_o;
   icache_pf_pkg::axi_ar_t                  axi_ar_o, last_ar;
   icache_pf_pkg::axi_r_t                   axi_r_i;
   logic                                    axi_arvalid_o, axi_arready_i;
   logic                                    axi_rvalid_i, axi_rready_o;

   row_t                      rows [NROWS];
   integer                    seed = 32'h1e99497c;
   int                        cycle, ar_count, err_value, err_proto, rr_ptr;
   logic                      started, flushing, ack_seen;
   logic [NB:0]               pending, gnt_seen;     // One bit per requester, prefetch on bit NB
   int                        gnt_cyc [NB+1];
   int                        rsp_cyc [NB+1];
   logic [`ICACHE_LINE_W-1:0] rsp_line [NB+1];
   int                        mem_state, ar_delay, beat;
   logic [`ICACHE_ADDR_W-1:0] ar_addr;
   logic [`ICACHE_ID_W-1:0]   ar_id;

   icache_pf_top DUT (.*);

   always #(PERIOD/2) clk = ~clk;

   // Beat k of line A in the memory image is {C0DE0000, A + 8k}
   function automatic logic [`ICACHE_LINE_W-1:0] model_line(input logic [31:0] addr);
      logic [31:0] base;
      base = {addr[31:4], 4'h0};
      return {32'hC0DE0000, base + 32'd8, 32'hC0DE0000, base};
   endfunction

   function automatic row_t make_row(input logic fl, input logic [NB:0] who,
                                     input logic [31:0] addr, input int stride, input int ars);
      return '{flush: fl, who: who, addr: addr, stride: stride, exp_ar: ars,
               line: model_line(addr)};
   endfunction

   task automatic value_error(input string msg);
      $display("** Error @%0t: %s", $time, msg);
      err_value++;
   endtask

   task automatic protocol_error(input string msg);
      $display("** Error @%0t: %s", $time, msg);
      err_proto++;
   endtask

   ////////////////////////////////////////////////////////////
   // AXI memory model driven on the falling edge
   always @(negedge clk) begin : axi_memory
      axi_arready_i = 1'b0;
      axi_rvalid_i  = 1'b0;
      axi_r_i       = '0;
      if (!rst_n_i) begin
         mem_state = 0;
      end else if (mem_state == 2) begin                 // Beats go out low address first
         axi_rvalid_i  = 1'b1;
         axi_r_i.rid   = ar_id;
         axi_r_i.rdata = {32'hC0DE0000, ar_addr + 32'(8 * beat)};
         axi_r_i.rlast = (beat == 1);
         mem_state     = (beat == 1) ? 0 : 2;
         beat          = beat + 1;
      end else begin
         if (mem_state == 0 && axi_arvalid_o) begin
            ar_delay  = $unsigned($random(seed)) % 4;   // 0 to 3 wait cycles
            mem_state = 1;
         end
         if (mem_state == 1) begin
            if (ar_delay == 0) begin
               axi_arready_i = 1'b1;                     // Handshake on the next edge
               ar_addr       = axi_ar_o.araddr;
               ar_id         = axi_ar_o.arid;
               beat          = 0;
               mem_state     = 2;
            end else begin
               ar_delay = ar_delay - 1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Monitor sampling a quarter period after the falling edge
   always begin : monitor
      int   win;
      logic found;
      @(negedge clk);
      #(PERIOD/4);
      cycle++;
      if (rst_n_i) begin
         if (!started && |{fetch_gnt_o, fetch_rvalid_o, pf_gnt_o, pf_rvalid_o, flush_ack_o,
                           axi_arvalid_o})
            protocol_error("output active after reset before any request");
         if (!axi_rready_o)
            protocol_error("AXI rready low, R beats would be refused");
         if (pf_gnt_o && |fetch_req_i)
            protocol_error("prefetch granted while a core requests");
         if (|fetch_gnt_o) begin
            found = 1'b0;
            win   = 0;
            for (int j = 0; j < NB; j++) begin
               if (!found && fetch_req_i[(rr_ptr + j) % NB]) begin
                  found = 1'b1;                          // First requester from the pointer
                  win   = (rr_ptr + j) % NB;
               end
            end
            if (!found || fetch_gnt_o != ({{(NB-1){1'b0}}, 1'b1} << win))
               protocol_error($sformatf("grant %b breaks round-robin order", fetch_gnt_o));
            rr_ptr = (win + 1) % NB;
         end
         for (int k = 0; k <= NB; k++) begin
            if ((k < NB) ? fetch_gnt_o[k] : pf_gnt_o) begin
               if (gnt_seen[k])
                  protocol_error($sformatf("requester %0d granted twice", k));
               gnt_seen[k] = 1'b1;
               gnt_cyc[k]  = cycle;
            end
            if ((k < NB) ? fetch_rvalid_o[k] : pf_rvalid_o) begin
               if (!pending[k])
                  protocol_error($sformatf("unexpected response to requester %0d", k));
               pending[k] = 1'b0;
               rsp_cyc[k] = cycle;
               if (k < NB)
                  rsp_line[k] = fetch_rdata_o[k];
            end
         end
         if (axi_arvalid_o && axi_arready_i) begin
            ar_count++;
            last_ar = axi_ar_o;
            if (axi_ar_o.arlen != 8'd1 || axi_ar_o.arsize != 3'd3 || axi_ar_o.arburst != 2'b01
                || axi_ar_o.araddr[3:0] != 4'h0 || !$onehot(axi_ar_o.arid))
               protocol_error($sformatf("bad AR fields %h", axi_ar_o));
         end
         if (flush_ack_o) begin
            if (!flushing)
               protocol_error("flush acknowledge without a flush request");
            ack_seen = 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // One table row with fetches or a flush
   task automatic apply_row(input row_t r);
      logic [NB:0]               left;
      int                        ar_before;
      logic [`ICACHE_LINE_W-1:0] exp;
      ar_before = ar_count;
      @(negedge clk);
      if (r.flush) begin
         flushing    = 1'b1;
         ack_seen    = 1'b0;
         flush_req_i = 1'b1;
         while (!ack_seen) @(negedge clk);
         flush_req_i = 1'b0;
         flushing    = 1'b0;
      end else begin
         gnt_seen = '0;
         pending  = r.who;
         left     = r.who;
         for (int k = 0; k < NB; k++) begin
            fetch_req_i[k]  = r.who[k];
            fetch_addr_i[k] = r.addr + r.stride * k;
         end
         pf_req_i  = r.who[NB];
         pf_addr_i = r.addr + r.stride * NB;
         while (left != 0) begin                       // Hold each request until granted
            @(negedge clk);
            for (int k = 0; k < NB; k++) begin
               if (left[k] && gnt_seen[k]) begin
                  fetch_req_i[k] = 1'b0;
                  left[k]        = 1'b0;
               end
            end
            if (left[NB] && gnt_seen[NB]) begin
               pf_req_i = 1'b0;
               left[NB] = 1'b0;
            end
         end
         while (pending != 0) @(negedge clk);
         for (int k = 0; k <= NB; k++) begin
            // Requester k sits k strides above the row line in both beat addresses
            exp = r.line + {2{32'h0, 32'(r.stride * k)}};
            if (r.who[k] && k < NB && rsp_line[k] !== exp)
               value_error($sformatf("core %0d line %h, expected %h", k, rsp_line[k], exp));
            if (r.who[k] && r.exp_ar == 0 && rsp_cyc[k] - gnt_cyc[k] != 2)
               value_error($sformatf("hit latency %0d cycles", rsp_cyc[k] - gnt_cyc[k]));
         end
      end
      if (ar_count - ar_before != r.exp_ar)
         value_error($sformatf("%0d AR bursts, expected %0d", ar_count - ar_before, r.exp_ar));
      if (r.exp_ar == 1 && (last_ar.arid != r.who || last_ar.araddr != {r.addr[31:4], 4'h0}))
         value_error($sformatf("AR id %b addr %h for %h", last_ar.arid, last_ar.araddr, r.addr));
   endtask

   initial begin : watchdog
      #(PERIOD * NROWS * 60);
      $display("Timeout: the run did not finish within %0d cycles", NROWS * 60);
      $display("** FAIL **");
      $finish;
   end

   initial begin : stimulus
      clk           = 1'b0;
      rst_n_i       = 1'b0;
      fetch_req_i   = '0;
      fetch_addr_i  = '0;
      pf_req_i      = 1'b0;
      pf_addr_i     = '0;
      flush_req_i   = 1'b0;
      axi_arready_i = 1'b0;
      axi_rvalid_i  = 1'b0;
      axi_r_i       = '0;
      {cycle, ar_count, err_value, err_proto, rr_ptr, mem_state} = '0;
      {started, flushing, ack_seen, pending, gnt_seen} = '0;
      rows[0]  = make_row(1'b0, 5'b00001, 32'h0000_1000, 0, 1);       // Cold miss
      rows[1]  = make_row(1'b0, 5'b00001, 32'h0000_1008, 0, 0);       // Same line hits
      rows[2]  = make_row(1'b0, 5'b00100, 32'h0000_1004, 0, 0);
      rows[3]  = make_row(1'b0, 5'b00010, 32'h0000_2010, 0, 1);
      rows[4]  = make_row(1'b0, 5'b10000, 32'h0000_2050, 0, 1);       // Prefetch fill
      rows[5]  = make_row(1'b0, 5'b01000, 32'h0000_2058, 0, 0);       // Prefetched line hits
      rows[6]  = make_row(1'b0, 5'b11111, 32'h0000_4080, 16, 5);      // All at once
      rows[7]  = make_row(1'b0, 5'b00010, 32'h0000_4090, 0, 0);
      rows[8]  = make_row(1'b1, 5'b00000, 32'h0, 0, 0);                // Flush
      rows[9]  = make_row(1'b0, 5'b00001, 32'h0000_1000, 0, 1);       // Misses again
      rows[10] = make_row(1'b0, 5'b00001, 32'h0001_1040, 0, 1);
      rows[11] = make_row(1'b0, 5'b00100, 32'h0002_1040, 0, 1);       // Same index with new tag
      rows[12] = make_row(1'b0, 5'b00001, 32'h0001_1040, 0, 1);       // Evicted before
      rows[13] = make_row(1'b0, 5'b10000, 32'h0001_1040, 0, 0);       // Prefetch hit
      repeat (4) @(negedge clk);                                      // Reset for 4 edges
      rst_n_i = 1'b1;
      repeat (3) @(negedge clk);
      started = 1'b1;
      for (int i = 0; i < NROWS; i++)
         apply_row(rows[i]);
      repeat (4) @(negedge clk);
      $display("Errors: %0d value, %0d protocol, %0d assertion", err_value, err_proto,
               DUT.u_asserts.fail_cnt);
      if (err_value + err_proto + DUT.u_asserts.fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
icache_pf_pkg.sv
icache_pf_arbiter.sv
icache_pf_stage_reg.sv
icache_pf_lookup.sv
icache_pf_refill.sv
icache_pf_top.sv
icache_pf_asserts.sv
tb_icache_pf.sv

// File: Bender.yml
package:
  name: icache_pf

export_include_dirs:
  - .

sources:
  - icache_pf_pkg.sv
  - icache_pf_arbiter.sv
  - icache_pf_stage_reg.sv
  - icache_pf_lookup.sv
  - icache_pf_refill.sv
  - icache_pf_top.sv
  - target: test
    files:
      - icache_pf_asserts.sv
      - tb_icache_pf.sv
